//--- compile.f
rnn_pkg.sv
mem_rd_if.sv
mac_if.sv
weight_memory.sv
mac_unit.sv
rnn_controller.sv
rnn_cell_top.sv
rnn_props.sv
tb_clock_gen.sv
rnn_tb.sv

//--- rnn_tb.sv
`default_nettype none

module rnn_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        rnn_pkg::token_t tok;
        logic            inject;    // extra execute while busy
    } row_t;

    localparam int n_rows = 10;
    localparam row_t stim [n_rows] = '{
        '{7'd5, 1'b0}, '{7'd20, 1'b0}, '{7'd33, 1'b1}, '{7'd20, 1'b0}, '{7'd75, 1'b0},
        '{7'd0, 1'b1}, '{7'd47, 1'b0}, '{7'd12, 1'b0}, '{7'd20, 1'b1}, '{7'd61, 1'b0}
    };
    localparam int timeout_cycles = n_rows * 300 + rnn_pkg::mem_depth + 20;

    logic                 clk, reset;
    logic                 wr_en, execute;
    rnn_pkg::addr_t       wr_addr;
    rnn_pkg::data_t       wr_data;
    rnn_pkg::token_t      token;
    logic                 busy, h_valid, step_done;
    rnn_pkg::hidden_idx_t h_index;
    rnn_pkg::data_t       h_value;

    rnn_pkg::data_t image [rnn_pkg::mem_depth];          // copy of the weight memory
    rnn_pkg::data_t model_hidden [rnn_pkg::hidden_size];
    logic [31:0]    seed = 32'hf68dacd8;
    int             value_errs = 0;
    int             proto_errs = 0;
    int             cycles = 0;
    int             n_sat = 0;
    int             n_zero = 0;

    tb_clock_gen clock_gen_0 (.clk(clk), .reset(reset));

    rnn_cell_top dut0 (
        .clk(clk), .reset(reset), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .execute(execute), .token(token), .busy(busy), .h_valid(h_valid),
        .h_index(h_index), .h_value(h_value), .step_done(step_done)
    );

    bind rnn_controller rnn_props props_0 (
        .clk(clk), .reset(reset), .busy(busy), .h_valid(h_valid), .step_done(step_done)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // q8.8 neuron from the old model state, 64-bit sum, saturate, relu
    function automatic rnn_pkg::data_t predict_neuron(input rnn_pkg::token_t tok, input int n);
        longint sum;
        longint q;
        int     k;
        sum = 0;
        for (k = 0; k < rnn_pkg::hidden_size; k++)
            sum += longint'(image[rnn_pkg::w_hh_base + n * rnn_pkg::hidden_size + k])
                   * longint'(model_hidden[k]);
        for (k = 0; k < rnn_pkg::embed_size; k++)
            sum += longint'(image[rnn_pkg::w_ih_base + n * rnn_pkg::embed_size + k])
                   * longint'(image[rnn_pkg::emb_base + tok * rnn_pkg::embed_size + k]);
        sum += longint'(image[rnn_pkg::b_hh_base + n]) * (longint'(1) << rnn_pkg::frac_bits);
        sum += longint'(image[rnn_pkg::b_ih_base + n]) * (longint'(1) << rnn_pkg::frac_bits);
        q = sum >>> rnn_pkg::frac_bits;
        if (q > 32767)
            q = 32767;
        else if (q < -32768)
            q = -32768;
        if (q < 0)
            q = 0;
        return rnn_pkg::data_t'(q);
    endfunction

    task automatic check_data(input string name, input rnn_pkg::data_t exp,
                              input rnn_pkg::data_t act);
        if (act !== exp)
        begin
            $display("Fail at %0d ns: %s expected %h got %h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_index(input string name, input rnn_pkg::hidden_idx_t exp,
                               input rnn_pkg::hidden_idx_t act);
        if (act !== exp)
        begin
            $display("Fail at %0d ns: %s expected %0d got %0d", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Fail at %0d ns: %s expected %b got %b", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic build_image();
        int a;
        for (a = 0; a < rnn_pkg::mem_depth; a++)
        begin
            seed     = lcg_next(seed);
            image[a] = rnn_pkg::data_t'($signed(seed[23:16]));   // about +-0.5
        end
        // neuron 3 always negative, hidden inputs are never below zero
        for (a = 0; a < rnn_pkg::hidden_size; a++)
            image[rnn_pkg::w_hh_base + 3 * rnn_pkg::hidden_size + a] = rnn_pkg::data_t'(-128);
        image[rnn_pkg::b_hh_base + 3] = 16'hc000;
        image[rnn_pkg::b_ih_base + 3] = 16'hc000;
        // token 20 drives neuron 5 far past the top of the range
        image[rnn_pkg::emb_base + 20 * rnn_pkg::embed_size] = 16'h7f00;
        image[rnn_pkg::w_ih_base + 5 * rnn_pkg::embed_size] = 16'h7f00;
    endtask

    task automatic write_image();
        int a;
        for (a = 0; a < rnn_pkg::mem_depth; a++)
        begin
            @(negedge clk);
            wr_en   = 1'b1;
            wr_addr = rnn_pkg::addr_t'(a);
            wr_data = image[a];
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic run_step(input row_t row);
        rnn_pkg::data_t exp [rnn_pkg::hidden_size];
        int             n_out;
        int             cyc;
        logic           done;
        for (int n = 0; n < rnn_pkg::hidden_size; n++)
            exp[n] = predict_neuron(row.tok, n);
        model_hidden = exp;
        @(negedge clk);
        check_flag("busy", 1'b0, busy);
        execute = 1'b1;
        token   = row.tok;
        n_out   = 0;
        cyc     = 0;
        done    = 1'b0;
        while (!done)
        begin
            @(negedge clk);
            cyc++;
            execute = 1'b0;
            if (row.inject && (cyc == 2))
            begin
                if (!busy)
                begin
                    $display("extra execute could not be placed, the step was not running");
                    proto_errs++;
                end
                execute = 1'b1;
                token   = 7'd70;
            end
            if (h_valid)
            begin
                if (n_out >= rnn_pkg::hidden_size)
                begin
                    $display("more than eight h_valid strobes in one step at %0d ns", $time);
                    proto_errs++;
                end
                else
                begin
                    check_index("h_index", rnn_pkg::hidden_idx_t'(n_out), h_index);
                    check_data("h_value", exp[n_out], h_value);
                    if (exp[n_out] == 16'h7fff && h_value === exp[n_out])
                        n_sat++;
                    if (exp[n_out] == 16'h0000 && h_value === exp[n_out])
                        n_zero++;
                end
                n_out++;
            end
            if (step_done)
            begin
                done = 1'b1;
                if (n_out != rnn_pkg::hidden_size)
                begin
                    $display("step ended after %0d results instead of eight", n_out);
                    proto_errs++;
                end
                check_flag("busy", 1'b0, busy);
            end
        end
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles)
        begin
            $display("run stopped after %0d cycles, a step never finished", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial
    begin
        int fails;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        execute = 1'b0;
        token   = '0;
        model_hidden = '{default: '0};     // hidden state is zero after reset
        build_image();
        wait (reset === 1'b0);
        @(negedge clk);
        check_flag("busy", 1'b0, busy);
        check_flag("h_valid", 1'b0, h_valid);
        check_flag("step_done", 1'b0, step_done);
        write_image();
        for (int r = 0; r < n_rows; r++)
            run_step(stim[r]);
        if (n_sat == 0 || n_zero == 0)
        begin
            $display("the table never reached a saturated or a clamped-to-zero result");
            proto_errs++;
        end
        fails = dut0.rnn_controller_0.props_0.fail_cnt;
        $display("errors: %0d value, %0d protocol, %0d assertion", value_errs, proto_errs, fails);
        if (value_errs == 0 && proto_errs == 0 && fails == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;      // 10 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;               // released on a falling edge
    end

endmodule

`default_nettype wire

//--- rnn_props.sv
`default_nettype none

module rnn_props (
    input logic clk,
    input logic reset,
    input logic busy,
    input logic h_valid,
    input logic step_done
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;   // read by the testbench

    step_done_single: assert property (@(posedge clk) disable iff (reset)
        step_done |=> !step_done)
    else
    begin
        $error("step_done held for more than one cycle");
        fail_cnt = fail_cnt + 1;
    end

    h_valid_in_step: assert property (@(posedge clk) disable iff (reset)
        h_valid |-> busy)
    else
    begin
        $error("h_valid outside a running step");
        fail_cnt = fail_cnt + 1;
    end

    idle_after_done: assert property (@(posedge clk) disable iff (reset)
        step_done |=> !busy)
    else
    begin
        $error("busy high in the cycle after step_done");
        fail_cnt = fail_cnt + 1;
    end

endmodule

`default_nettype wire

//--- rnn_cell_top.sv
`default_nettype none

module rnn_cell_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wr_en,
    input  rnn_pkg::addr_t       wr_addr,
    input  rnn_pkg::data_t       wr_data,
    input  logic                 execute,
    input  rnn_pkg::token_t      token,
    output logic                 busy,
    output logic                 h_valid,
    output rnn_pkg::hidden_idx_t h_index,
    output rnn_pkg::data_t       h_value,
    output logic                 step_done
);

    mem_rd_if mem_rd ();
    mac_if    mac_bus ();

    weight_memory weight_memory_0 (
        .clk     (clk),
        .wr_en   (wr_en),       // loaded by the host while idle
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd      (mem_rd.responder)
    );

    rnn_controller rnn_controller_0 (
        .clk       (clk),
        .reset     (reset),
        .execute   (execute),
        .token     (token),
        .busy      (busy),
        .h_valid   (h_valid),
        .h_index   (h_index),
        .h_value   (h_value),
        .step_done (step_done),
        .rd        (mem_rd.requester),
        .mac       (mac_bus.source)
    );

    mac_unit mac_unit_0 (
        .clk   (clk),
        .reset (reset),
        .mac   (mac_bus.sink)
    );

endmodule

`default_nettype wire

//--- rnn_controller.sv
`default_nettype none

module rnn_controller (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 execute,
    input  rnn_pkg::token_t      token,
    output logic                 busy,
    output logic                 h_valid,
    output rnn_pkg::hidden_idx_t h_index,
    output rnn_pkg::data_t       h_value,
    output logic                 step_done,
    mem_rd_if.requester          rd,
    mac_if.source                mac
);

    rnn_pkg::ctrl_state_e  state;
    rnn_pkg::token_t       tok_q;
    rnn_pkg::read_cnt_t    cnt;            // read index within a phase
    rnn_pkg::hidden_idx_t  neuron;
    rnn_pkg::data_t        embed_q    [rnn_pkg::embed_size];
    rnn_pkg::data_t        old_hidden [rnn_pkg::hidden_size];
    rnn_pkg::data_t        new_hidden [rnn_pkg::hidden_size];

    rnn_pkg::operand_sel_e sel_c, sel_d;
    rnn_pkg::hidden_idx_t  idx_c, idx_d;   // operand index, one cycle behind the read
    rnn_pkg::read_cnt_t    ih_cnt;
    logic                  issue_d, emb_cap_d, first_d, last_d;

    assign ih_cnt = rnn_pkg::read_cnt_t'(cnt - (rnn_pkg::hidden_size + 1));
    assign rd.rd_en = (state == rnn_pkg::load_emb) || (state == rnn_pkg::issue);

    // address decode: w_hh x8, b_hh, w_ih x4, b_ih
    always_comb
    begin
        rd.rd_addr = '0;
        sel_c      = rnn_pkg::bias_one;
        idx_c      = '0;
        if (state == rnn_pkg::load_emb)
        begin
            rd.rd_addr = rnn_pkg::addr_t'(rnn_pkg::emb_base + tok_q * rnn_pkg::embed_size + cnt);
            idx_c      = rnn_pkg::hidden_idx_t'(cnt);
        end
        else if (cnt < rnn_pkg::hidden_size)
        begin
            rd.rd_addr = rnn_pkg::addr_t'(rnn_pkg::w_hh_base
                                          + neuron * rnn_pkg::hidden_size + cnt);
            sel_c      = rnn_pkg::hidden;
            idx_c      = rnn_pkg::hidden_idx_t'(cnt);
        end
        else if (cnt == rnn_pkg::hidden_size)
        begin
            rd.rd_addr = rnn_pkg::addr_t'(rnn_pkg::b_hh_base + neuron);
        end
        else if (cnt < rnn_pkg::n_reads - 1)
        begin
            rd.rd_addr = rnn_pkg::addr_t'(rnn_pkg::w_ih_base
                                          + neuron * rnn_pkg::embed_size + ih_cnt);
            sel_c      = rnn_pkg::embed;
            idx_c      = rnn_pkg::hidden_idx_t'(ih_cnt);
        end
        else
        begin
            rd.rd_addr = rnn_pkg::addr_t'(rnn_pkg::b_ih_base + neuron);
        end
    end

    // operand tags travel with the read
    always_ff @(posedge clk)
    begin
        sel_d <= sel_c;
        idx_d <= idx_c;
        if (reset)
        begin
            issue_d   <= 1'b0;
            emb_cap_d <= 1'b0;
            first_d   <= 1'b0;
            last_d    <= 1'b0;
        end
        else
        begin
            issue_d   <= (state == rnn_pkg::issue);
            emb_cap_d <= (state == rnn_pkg::load_emb);
            first_d   <= (state == rnn_pkg::issue) && (cnt == 0);
            last_d    <= (state == rnn_pkg::issue) && (cnt == rnn_pkg::n_reads - 1);
        end
    end

    assign mac.in_valid = issue_d & rd.rd_valid;
    assign mac.a        = rd.rd_data;
    assign mac.first    = first_d;
    assign mac.last     = last_d;

    always_comb
    begin
        case (sel_d)
            rnn_pkg::hidden: mac.b = old_hidden[idx_d];
            rnn_pkg::embed:  mac.b = embed_q[rnn_pkg::embed_idx_t'(idx_d)];
            default:         mac.b = rnn_pkg::one_q;
        endcase
    end

    // payload capture
    always_ff @(posedge clk)
    begin
        if ((state == rnn_pkg::idle) && execute)
            tok_q <= token;
        if (emb_cap_d && rd.rd_valid)
            embed_q[rnn_pkg::embed_idx_t'(idx_d)] <= rd.rd_data;
        if ((state == rnn_pkg::drain) && mac.out_valid)
        begin
            new_hidden[neuron] <= mac.result;
            h_index            <= neuron;
            h_value            <= mac.result;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= rnn_pkg::idle;
            busy       <= 1'b0;
            h_valid    <= 1'b0;
            step_done  <= 1'b0;
            cnt        <= '0;
            neuron     <= '0;
            old_hidden <= '{default: '0};
        end
        else
        begin
            h_valid   <= 1'b0;
            step_done <= 1'b0;
            case (state)
                rnn_pkg::idle:
                    if (execute)
                    begin
                        busy   <= 1'b1;
                        cnt    <= '0;
                        neuron <= '0;
                        state  <= rnn_pkg::load_emb;
                    end
                rnn_pkg::load_emb:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == rnn_pkg::embed_size - 1)
                    begin
                        cnt   <= '0;
                        state <= rnn_pkg::issue;    // embedding lands before w_ih data
                    end
                end
                rnn_pkg::issue:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == rnn_pkg::n_reads - 1)
                        state <= rnn_pkg::drain;
                end
                rnn_pkg::drain:
                    if (mac.out_valid)
                    begin
                        h_valid <= 1'b1;
                        cnt     <= '0;
                        if (neuron == rnn_pkg::hidden_size - 1)
                            state <= rnn_pkg::commit;
                        else
                        begin
                            neuron <= neuron + 1'b1;
                            state  <= rnn_pkg::issue;
                        end
                    end
                default:
                begin
                    old_hidden <= new_hidden;        // new state feeds next token
                    step_done  <= 1'b1;
                    busy       <= 1'b0;
                    state      <= rnn_pkg::idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- mac_unit.sv
`default_nettype none

module mac_unit (
    input  logic clk,
    input  logic reset,
    mac_if.sink  mac
);

    logic signed [2*rnn_pkg::data_w-1:0] prod_q;      // full q16.16 product
    logic                                p_valid;
    logic                                p_first;
    logic                                p_last;
    logic signed [rnn_pkg::acc_w-1:0]    prod_ext;
    logic signed [rnn_pkg::acc_w-1:0]    acc_q;
    logic                                s_last;
    logic signed [rnn_pkg::acc_w-1:0]    shifted;
    rnn_pkg::data_t                      sat;
    rnn_pkg::data_t                      relu;

    // stage one, multiply
    always_ff @(posedge clk)
    begin
        prod_q  <= mac.a * mac.b;
        p_first <= mac.first;
        if (reset)
        begin
            p_valid <= 1'b0;
            p_last  <= 1'b0;
        end
        else
        begin
            p_valid <= mac.in_valid;
            p_last  <= mac.in_valid & mac.last;
        end
    end

    assign prod_ext = prod_q;   // sign extends

    // stage two, accumulate
    always_ff @(posedge clk)
    begin
        if (p_valid)
        begin
            acc_q <= p_first ? prod_ext : acc_q + prod_ext;
        end
        if (reset)
            s_last <= 1'b0;
        else
            s_last <= p_valid & p_last;
    end

    // back to q8.8, clamp, then relu
    assign shifted = acc_q >>> rnn_pkg::frac_bits;

    always_comb
    begin
        if (shifted > rnn_pkg::q_max)
            sat = rnn_pkg::data_t'(rnn_pkg::q_max);
        else if (shifted < rnn_pkg::q_min)
            sat = rnn_pkg::data_t'(rnn_pkg::q_min);
        else
            sat = rnn_pkg::data_t'(shifted);
    end

    assign relu = sat[rnn_pkg::data_w-1] ? '0 : sat;

    always_ff @(posedge clk)
    begin
        if (s_last)
            mac.result <= relu;
        if (reset)
            mac.out_valid <= 1'b0;
        else
            mac.out_valid <= s_last;
    end

endmodule

`default_nettype wire

//--- weight_memory.sv
`default_nettype none

module weight_memory (
    input  logic             clk,
    input  logic             wr_en,
    input  rnn_pkg::addr_t   wr_addr,
    input  rnn_pkg::data_t   wr_data,
    mem_rd_if.responder      rd
);

    rnn_pkg::data_t mem [rnn_pkg::mem_depth];

    always_ff @(posedge clk)
    begin
        if (wr_en && (wr_addr < rnn_pkg::mem_depth))   // top of the address range is unmapped
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data and flag line up one cycle after rd_en
    always_ff @(posedge clk)
    begin
        if (rd.rd_en)
        begin
            rd.rd_data <= mem[rd.rd_addr];
        end
    end

    always_ff @(posedge clk)
    begin
        rd.rd_valid <= rd.rd_en;
    end

endmodule

`default_nettype wire

//--- mac_if.sv
`default_nettype none

interface mac_if;

    logic           in_valid;
    rnn_pkg::data_t a;          // weight or bias word
    rnn_pkg::data_t b;          // hidden, embedding or 1.0
    logic           first;      // restarts the sum
    logic           last;       // closes the sum
    logic           out_valid;  // one-cycle strobe
    rnn_pkg::data_t result;

    modport source (
        output in_valid, a, b, first, last,
        input  out_valid, result
    );

    modport sink (
        input  in_valid, a, b, first, last,
        output out_valid, result
    );

endinterface

`default_nettype wire

//--- mem_rd_if.sv
`default_nettype none

interface mem_rd_if;

    logic          rd_en;
    rnn_pkg::addr_t rd_addr;
    rnn_pkg::data_t rd_data;   // valid one cycle after rd_en
    logic          rd_valid;

    modport requester (
        output rd_en,
        output rd_addr,
        input  rd_data,
        input  rd_valid
    );

    modport responder (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        output rd_valid
    );

endinterface

`default_nettype wire

//--- rnn_pkg.sv
`default_nettype none

package rnn_pkg;

    localparam int vocab_size   = 76;
    localparam int embed_size   = 4;
    localparam int hidden_size  = 8;
    localparam int data_w       = 16;                 // q8.8
    localparam int frac_bits    = 8;
    localparam int acc_w        = 40;                 // room for 14 full products
    localparam int token_w      = 7;
    localparam int addr_w       = 9;
    localparam int hidden_idx_w = 3;
    localparam int embed_idx_w  = $clog2(embed_size);
    localparam int n_reads      = hidden_size + embed_size + 2;   // w_hh, b_hh, w_ih, b_ih
    localparam int read_cnt_w   = $clog2(n_reads);

    // weight memory map, one q8.8 word per parameter
    localparam int emb_base  = 0;
    localparam int w_ih_base = emb_base + vocab_size * embed_size;     // 304
    localparam int w_hh_base = w_ih_base + hidden_size * embed_size;   // 336
    localparam int b_ih_base = w_hh_base + hidden_size * hidden_size;  // 400
    localparam int b_hh_base = b_ih_base + hidden_size;                // 408
    localparam int mem_depth = b_hh_base + hidden_size;                // 416

    typedef logic signed [data_w-1:0] data_t;
    typedef logic [addr_w-1:0]        addr_t;
    typedef logic [token_w-1:0]       token_t;
    typedef logic [hidden_idx_w-1:0]  hidden_idx_t;
    typedef logic [embed_idx_w-1:0]   embed_idx_t;
    typedef logic [read_cnt_w-1:0]    read_cnt_t;

    localparam data_t one_q = data_t'(1 << frac_bits);  // 1.0, bias multiplier
    localparam int    q_max = (1 << (data_w - 1)) - 1;  // saturation limits
    localparam int    q_min = -(1 << (data_w - 1));

    typedef enum logic [2:0] {
        idle,
        load_emb,
        issue,
        drain,
        commit
    } ctrl_state_e;

    typedef enum logic [1:0] {
        hidden,
        embed,
        bias_one
    } operand_sel_e;

endpackage

`default_nettype wire
